// File: Makefile
# Verilator build and run for the Tomasulo core testbench

VERILATOR ?= verilator
TOP       ?= tomasuloTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/aluPipe.sv
`timescale 1ns/1ns

module aluPipe
    import tomasuloPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  opcode_e           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic [TAG_W-1:0]  tagIn,
    input  logic              accept,
    output logic              ready,
    output logic              request,
    output cdb_t              result
);

    cdb_t              stageOne;
    // holding register toward the arbiter
    cdb_t              stageTwo;
    logic [DATA_W-1:0] aluOut;
    logic              advance;

    // ------------------------------------------------------------------
    // arithmetic
    // ------------------------------------------------------------------
    always_comb begin
        case (op)
            OP_ADD, OP_ADDI: aluOut = a + b;
            OP_SUB:          aluOut = a - b;
            OP_OR, OP_ORI:   aluOut = a | b;
            OP_XOR:          aluOut = a ^ b;
            OP_SLL:          aluOut = a << b[$clog2(DATA_W)-1:0];
            // low word of the product
            OP_MUL:          aluOut = a * b;
            default:         aluOut = '0;
        endcase
    end

    // stage two moves when empty or drained this cycle
    assign advance = !stageTwo.valid || accept;
    assign ready   = !stageOne.valid || advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageOne.valid <= 1'b0;
            stageTwo.valid <= 1'b0;
        end else begin
            if (advance) begin
                stageTwo <= stageOne;
            end
            if (ready) begin
                stageOne.valid <= start;
                stageOne.tag   <= tagIn;
                stageOne.value <= aluOut;
            end
        end
    end

    assign request = stageTwo.valid;
    assign result  = stageTwo;

endmodule

// File: design/cdbArbiter.sv
`timescale 1ns/1ns

module cdbArbiter
    import tomasuloPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_UNITS-1:0] request,
    input  cdb_t                 results [NUM_UNITS],
    output logic [NUM_UNITS-1:0] accept,
    output cdb_t                 cdb
);

    // slice granted last, search starts one above it
    logic [UNIT_W-1:0] lastGrant;
    logic [UNIT_W-1:0] grantIdx;
    logic              granted;

    // ------------------------------------------------------------------
    // round-robin grant
    // ------------------------------------------------------------------
    always_comb begin
        int idx;
        accept   = '0;
        grantIdx = lastGrant;
        granted  = 1'b0;
        for (int i = 1; i <= NUM_UNITS; i++) begin
            idx = (int'(lastGrant) + i) % NUM_UNITS;
            // first requester in rotated order
            if (!granted && request[idx]) begin
                accept[idx] = 1'b1;
                grantIdx    = UNIT_W'(idx);
                granted     = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // bus register, one cycle after accept
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
            lastGrant <= '0;
        end else begin
            cdb.valid <= granted;
            if (granted) begin
                lastGrant <= grantIdx;
                cdb.tag   <= results[grantIdx].tag;
                cdb.value <= results[grantIdx].value;
            end
        end
    end

endmodule

// File: design/issueUnit.sv
`timescale 1ns/1ns

module issueUnit
    import tomasuloPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // host port
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]     pwdata,
    output logic [DATA_W-1:0]     prdata,
    output logic                  pready,
    // slices
    input  logic [NUM_UNITS-1:0]  free,
    output dispatch_t             dispatch,
    output logic [NUM_UNITS-1:0]  dispatchSel,
    // broadcast
    input  cdb_t                  cdb
);

    // committed values and rename table
    logic [DATA_W-1:0]             regVal [NUM_REGS];
    logic [TAG_W-1:0]              regTag [NUM_REGS];
    // tag held from dispatch until its own broadcast
    logic [NUM_UNITS*RS_DEPTH-1:0] tagBusy;

    instrWord_u         instr;
    logic               isImm;
    logic [DATA_W-1:0]  immExt;
    logic               issueWrite;
    logic               issueFire;
    logic               anyFree;
    logic               anyTag;
    logic [UNIT_W-1:0]  selUnit;
    logic [ENTRY_W-1:0] selEntry;
    logic [TAG_W-1:0]   newTag;
    logic               regHit;
    logic [REG_W-1:0]   regIdx;

    // register read with same-cycle bus forwarding
    function automatic operand_t readOperand(input logic [REG_W-1:0] idx);
        operand_t opnd;
        opnd.tag   = regTag[idx];
        opnd.value = regVal[idx];
        if (cdb.valid && opnd.tag != '0 && opnd.tag == cdb.tag) begin
            opnd.tag   = '0;
            opnd.value = cdb.value;
        end
        return opnd;
    endfunction

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    assign instr = pwdata;
    assign isImm = instr.rType.opcode inside {OP_ADDI, OP_ORI};

    // addi sign-extends, ori zero-extends
    always_comb begin
        if (instr.iType.opcode == OP_ADDI) begin
            immExt = {{(DATA_W-IMM_W){instr.iType.imm[IMM_W-1]}}, instr.iType.imm};
        end else begin
            immExt = {{(DATA_W-IMM_W){1'b0}}, instr.iType.imm};
        end
    end

    // ------------------------------------------------------------------
    // slice and tag choice
    // ------------------------------------------------------------------
    assign anyFree = |free;

    // lowest free slice
    always_comb begin
        selUnit = '0;
        for (int u = NUM_UNITS - 1; u >= 0; u--) begin
            if (free[u]) begin
                selUnit = UNIT_W'(u);
            end
        end
    end

    // first idle entry of that slice, same order the station uses
    always_comb begin
        selEntry = '0;
        for (int e = RS_DEPTH - 1; e >= 0; e--) begin
            if (!tagBusy[int'(selUnit) * RS_DEPTH + e]) begin
                selEntry = ENTRY_W'(e);
            end
        end
    end

    assign newTag = TAG_W'(int'(selUnit) * RS_DEPTH + int'(selEntry) + 1);

    // ------------------------------------------------------------------
    // APB
    // ------------------------------------------------------------------
    assign issueWrite = psel && penable && pwrite && (paddr == ADDR_ISSUE);
    assign issueFire  = issueWrite && anyFree;
    // issue write waits here while every slice is full
    assign pready     = psel && penable && (!issueWrite || anyFree);

    assign regHit = (paddr >= ADDR_REG_BASE)
                 && (int'(paddr) < int'(ADDR_REG_BASE) + 4 * NUM_REGS)
                 && (paddr[1:0] == 2'b00);
    assign regIdx = REG_W'((paddr - ADDR_REG_BASE) >> 2);

    // outstanding work
    always_comb begin
        anyTag = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            anyTag = anyTag | (regTag[r] != '0);
        end
    end

    always_comb begin
        prdata = '0;
        if (regHit) begin
            prdata = regVal[regIdx];
        end else if (paddr == ADDR_STATUS) begin
            prdata = DATA_W'(anyTag);
        end
    end

    // ------------------------------------------------------------------
    // dispatch record
    // ------------------------------------------------------------------
    always_comb begin
        dispatch.valid = issueFire;
        dispatch.op    = instr.rType.opcode;
        dispatch.dest  = newTag;
        dispatch.a     = readOperand(instr.rType.rs);
        if (isImm) begin
            dispatch.b.tag   = '0;
            dispatch.b.value = immExt;
        end else begin
            dispatch.b = readOperand(instr.rType.rt);
        end
    end

    assign dispatchSel = issueFire ? (NUM_UNITS'(1) << selUnit) : '0;

    // write-back first, then rename of the destination
    always_ff @(posedge clk) begin
        if (rst) begin
            regVal  <= '{default: '0};
            regTag  <= '{default: '0};
            tagBusy <= '0;
        end else begin
            if (cdb.valid) begin
                tagBusy[int'(cdb.tag) - 1] <= 1'b0;
                // only the newest producer of a register commits it
                for (int r = 0; r < NUM_REGS; r++) begin
                    if (regTag[r] == cdb.tag) begin
                        regVal[r] <= cdb.value;
                        regTag[r] <= '0;
                    end
                end
            end
            if (issueFire) begin
                regTag[instr.rType.rd]      <= newTag;
                tagBusy[int'(newTag) - 1]   <= 1'b1;
            end
        end
    end

endmodule

// File: design/reservationStation.sv
`timescale 1ns/1ns

module reservationStation
    import tomasuloPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // from issue
    input  dispatch_t dispatch,
    input  logic      load,
    // broadcast snoop
    input  cdb_t      cdb,
    // to arbiter
    input  logic      accept,
    output logic      free,
    output logic      request,
    output cdb_t      result
);

    // one station slot
    typedef struct packed {
        opcode_e          op;
        logic [TAG_W-1:0] tag;
        operand_t         a;
        operand_t         b;
    } rsEntry_t;

    rsEntry_t            entry [RS_DEPTH];
    // slot owns its tag until the result is broadcast
    logic [RS_DEPTH-1:0] busy;
    // slot still waits to enter the pipeline
    logic [RS_DEPTH-1:0] waiting;
    logic [RS_DEPTH-1:0] entryReady;
    logic [ENTRY_W-1:0]  loadIdx;
    logic [ENTRY_W-1:0]  issueIdx;
    logic                anyReady;
    logic                pipeReady;
    logic                start;

    assign free = ~&busy;

    // slot index comes from the tag offset
    assign loadIdx = ENTRY_W'((int'(dispatch.dest) - 1) % RS_DEPTH);

    // ------------------------------------------------------------------
    // ready selection
    // ------------------------------------------------------------------
    always_comb begin
        for (int e = 0; e < RS_DEPTH; e++) begin
            entryReady[e] = waiting[e] && (entry[e].a.tag == '0)
                         && (entry[e].b.tag == '0);
        end
    end

    // lowest index wins
    always_comb begin
        anyReady = 1'b0;
        issueIdx = '0;
        for (int e = RS_DEPTH - 1; e >= 0; e--) begin
            if (entryReady[e]) begin
                anyReady = 1'b1;
                issueIdx = ENTRY_W'(e);
            end
        end
    end

    assign start = anyReady && pipeReady;

    // ------------------------------------------------------------------
    // slot update
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= '0;
            waiting <= '0;
        end else begin
            for (int e = 0; e < RS_DEPTH; e++) begin
                // operand capture off the bus
                if (cdb.valid && entry[e].a.tag == cdb.tag) begin
                    entry[e].a.tag   <= '0;
                    entry[e].a.value <= cdb.value;
                end
                if (cdb.valid && entry[e].b.tag == cdb.tag) begin
                    entry[e].b.tag   <= '0;
                    entry[e].b.value <= cdb.value;
                end
                // own result seen, tag may be reused
                if (cdb.valid && busy[e] && entry[e].tag == cdb.tag) begin
                    busy[e] <= 1'b0;
                end
            end
            if (start) begin
                waiting[issueIdx] <= 1'b0;
            end
            // loaded slot is never busy, no clash with the clears above
            if (load && dispatch.valid) begin
                busy[loadIdx]     <= 1'b1;
                waiting[loadIdx]  <= 1'b1;
                entry[loadIdx].op  <= dispatch.op;
                entry[loadIdx].tag <= dispatch.dest;
                entry[loadIdx].a   <= dispatch.a;
                entry[loadIdx].b   <= dispatch.b;
            end
        end
    end

    // execution pipe
    aluPipe pipe0 (
        .clk,
        .rst,
        .start,
        .op      (entry[issueIdx].op),
        .a       (entry[issueIdx].a.value),
        .b       (entry[issueIdx].b.value),
        .tagIn   (entry[issueIdx].tag),
        .accept,
        .ready   (pipeReady),
        .request,
        .result
    );

endmodule

// File: design/tomasuloPkg.sv
package tomasuloPkg;

    // ------------------------------------------------------------------
    // core sizing
    // ------------------------------------------------------------------
    localparam int NUM_REGS  = 16;
    localparam int DATA_W    = 32;
    localparam int NUM_UNITS = 2;
    localparam int RS_DEPTH  = 2;
    // tag 0 = value present, else unit*RS_DEPTH + entry + 1
    localparam int TAG_W     = 3;

    // derived index widths
    localparam int REG_W   = $clog2(NUM_REGS);
    localparam int UNIT_W  = $clog2(NUM_UNITS);
    localparam int ENTRY_W = $clog2(RS_DEPTH);
    localparam int IMM_W   = 16;

    // ------------------------------------------------------------------
    // host register map
    // ------------------------------------------------------------------
    localparam int APB_ADDR_W = 8;
    localparam logic [APB_ADDR_W-1:0] ADDR_ISSUE    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS   = 8'h04;
    // register r sits at base + 4*r
    localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 8'h40;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_OR   = 4'h2,
        OP_XOR  = 4'h3,
        OP_SLL  = 4'h4,
        OP_MUL  = 4'h5,
        OP_ADDI = 4'h6,
        OP_ORI  = 4'h7
    } opcode_e;

    // ------------------------------------------------------------------
    // instruction word, opcode in the top nibble of both views
    // ------------------------------------------------------------------
    typedef struct packed {
        opcode_e            opcode;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [IMM_W-1:0]   unused;
    } rTypeWord_t;

    // pad lines up with rt, immediate in the low half
    typedef struct packed {
        opcode_e            opcode;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   pad;
        logic [IMM_W-1:0]   imm;
    } iTypeWord_t;

    typedef union packed {
        rTypeWord_t rType;
        iTypeWord_t iType;
    } instrWord_u;

    // tagged operand
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } operand_t;

    typedef struct packed {
        logic             valid;
        opcode_e          op;
        logic [TAG_W-1:0] dest;
        operand_t         a;
        operand_t         b;
    } dispatch_t;

    // result bus word
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } cdb_t;

endpackage

// File: design/tomasuloTop.sv
`timescale 1ns/1ns

module tomasuloTop
    import tomasuloPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // host APB
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]     pwdata,
    output logic [DATA_W-1:0]     prdata,
    output logic                  pready
);

    // issue to slices
    dispatch_t            dispatch;
    logic [NUM_UNITS-1:0] dispatchSel;
    logic [NUM_UNITS-1:0] free;
    // slices to arbiter
    logic [NUM_UNITS-1:0] request;
    logic [NUM_UNITS-1:0] accept;
    cdb_t                 results [NUM_UNITS];
    // broadcast to all
    cdb_t                 cdb;

    issueUnit issue0 (
        .clk,
        .rst,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pready,
        .free,
        .dispatch,
        .dispatchSel,
        .cdb
    );

    // ------------------------------------------------------------------
    // functional slices
    // ------------------------------------------------------------------
    for (genvar u = 0; u < NUM_UNITS; u++) begin : slices
        reservationStation station (
            .clk,
            .rst,
            .dispatch,
            .load    (dispatchSel[u]),
            .cdb,
            .accept  (accept[u]),
            .free    (free[u]),
            .request (request[u]),
            .result  (results[u])
        );
    end

    cdbArbiter arb0 (
        .clk,
        .rst,
        .request,
        .results,
        .accept,
        .cdb
    );

endmodule

// File: list.f
design/tomasuloPkg.sv
design/aluPipe.sv
design/reservationStation.sv
design/issueUnit.sv
design/cdbArbiter.sv
design/tomasuloTop.sv
tb/cdb_assertions.sv
tb/tomasuloTb.sv

// File: tb/cdb_assertions.sv
`timescale 1ns/1ns

module cdbAssertions
    import tomasuloPkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic [NUM_UNITS-1:0] request,
    input logic [NUM_UNITS-1:0] accept,
    input cdb_t                 cdb
);

    // ------------------------------------------------------------------
    // grant
    // ------------------------------------------------------------------
    // one slice drained per cycle at most
    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(accept))
        else $error("more than one slice accepted in the same cycle");

    grantToRequester: assert property (@(posedge clk) disable iff (rst)
        (accept & ~request) == '0)
        else $error("accept given to a slice that is not requesting");

    // a waiting request stays up until its accept
    requestHeld: assert property (@(posedge clk) disable iff (rst)
        |(request & ~accept) |=>
            ((request & $past(request & ~accept)) == $past(request & ~accept)))
        else $error("request dropped before it was accepted");

    // ------------------------------------------------------------------
    // bus
    // ------------------------------------------------------------------
    busTagNonzero: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> cdb.tag != '0)
        else $error("bus valid with tag zero");

endmodule

bind cdbArbiter cdbAssertions cdbChecks (.clk, .rst, .request, .accept, .cdb);

// File: tb/tomasuloTb.sv
`timescale 1ns/1ns

module tomasuloTb
    import tomasuloPkg::*;
();

    localparam int    CLK_HALF        = 10;
    localparam int    RESET_CYCLES    = 10;
    localparam int    TEST_MEM        = 64;
    localparam int    CYCLES_PER_WORD = 200;
    localparam int    BASE_CYCLES     = 500;
    localparam string TEST_FILE       = "tb/tomasuloTests.txt";
    // no register or port decodes here
    localparam logic [APB_ADDR_W-1:0] ADDR_UNMAPPED = 8'h08;
    // first address past the register window
    localparam logic [APB_ADDR_W-1:0] ADDR_PAST_REGS = 8'h80;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [DATA_W-1:0]     pwdata;
    logic [DATA_W-1:0]     prdata;
    logic                  pready;

    // count, program words, then expected r0..r15
    logic [31:0] tests [TEST_MEM];
    int          wordCount;
    int          errorCount;
    logic        loaded;

    tomasuloTop dut0 (
        .clk,
        .rst,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pready
    );

    always #CLK_HALF clk = ~clk;

    // ------------------------------------------------------------------
    // host bus
    // ------------------------------------------------------------------
    // setup on one edge, access on the next, done at a high-ready negedge
    task automatic busAccess(input logic write, input logic [APB_ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        // issue writes wait here while all stations are full
        do begin
            @(negedge clk);
        end while (!pready);
        rdata = prdata;
    endtask

    task automatic writeWord(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unusedData;
        busAccess(1'b1, addr, data, unusedData);
    endtask

    task automatic readWord(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        busAccess(1'b0, addr, '0, data);
    endtask

    // back to idle after the last access of a burst
    task automatic releaseBus();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic checkValue(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] got);
        assert (got === expected) else begin
            errorCount++;
            $display("FAIL time=%0t %s expected=%h got=%h", $time, name, expected, got);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic requireTrue(input bit cond, input string what);
        assert (cond) else begin
            errorCount++;
            $display("error at time %0t: %s", $time, what);
            $display("Simulation failed");
            $fatal(1, "setup problem");
        end
    endtask

    // status bit 0 drops once every tag is back to zero
    task automatic waitIdle(output logic [DATA_W-1:0] status);
        do begin
            readWord(ADDR_STATUS, status);
        end while (status[0] !== 1'b0);
    endtask

    // ------------------------------------------------------------------
    // watchdog, budget scales with the program length
    // ------------------------------------------------------------------
    initial begin
        wait (loaded);
        repeat (CYCLES_PER_WORD * wordCount + BASE_CYCLES) @(posedge clk);
        $display("timeout: the program did not drain within %0d cycles",
                 CYCLES_PER_WORD * wordCount + BASE_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        logic [DATA_W-1:0] rdata;
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        loaded     = 1'b0;
        errorCount = 0;
        $readmemh(TEST_FILE, tests);
        wordCount = int'(tests[0]);
        requireTrue(wordCount > 0 && wordCount + 1 + NUM_REGS <= TEST_MEM,
                    "instruction count in the data file is out of range");
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // registers and status come out of reset clear
        readWord(ADDR_REG_BASE + 8'd20, rdata);
        checkValue("r5 after reset", '0, rdata);
        readWord(ADDR_STATUS, rdata);
        checkValue("status after reset", '0, rdata);
        // write to a hole is dropped, so nothing gets renamed
        writeWord(ADDR_UNMAPPED, 32'hDEADBEEF);
        readWord(ADDR_STATUS, rdata);
        checkValue("status after unmapped write", '0, rdata);

        // whole program back to back
        for (int i = 1; i <= wordCount; i++) begin
            writeWord(ADDR_ISSUE, tests[i]);
        end
        // last issue is still at least four cycles from its broadcast
        readWord(ADDR_STATUS, rdata);
        checkValue("status while busy", 32'h1, rdata);
        waitIdle(rdata);
        checkValue("status", '0, rdata);

        readWord(ADDR_UNMAPPED, rdata);
        checkValue("unmapped 0x08", '0, rdata);
        readWord(ADDR_PAST_REGS, rdata);
        checkValue("unmapped 0x80", '0, rdata);

        for (int r = 0; r < NUM_REGS; r++) begin
            readWord(APB_ADDR_W'(int'(ADDR_REG_BASE) + 4 * r), rdata);
            checkValue($sformatf("r%0d", r), tests[wordCount + 1 + r], rdata);
        end
        releaseBus();

        if (errorCount == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: tb/tomasuloTests.txt
// word 0: instruction count; then instruction words, opcode rd rs rt/imm16 per nibble
// last 16 words: expected r0..r15 once the program has drained
00000018
// constants via ori from r0, zero-extended
71001234 72000005 7300FFFF
// dependent chain: add sub xor or sll mul
04120000 15430000 36510000 27620000 48720000 59810000
// addi with negative immediates
6A20FFFD 6B008000 6AA0FFFF
// three writes to r12, last one wins
7C000011 0C110000 5C220000
// independent burst, more than the four station entries
7D0000AA 7E000F00 6F000007 60000100 64400006
// short chains on the burst results, r0 used as an ordinary source
4EE20000 1FFD0000 233E0000 6200FF00
// expected r0..r3
00000100 00001234 00000000 0001FFFF
// expected r4..r7
0000123F FFFF123A FFFF000E FFFF000F
// expected r8..r11
FFE001E0 B9A22180 00000001 FFFF8000
// expected r12..r15
00000019 000000AA 0001E000 FFFFFF5D
